/* usb_rx_decode.f */
+incdir+verif
rtl/usb_rx_pkg.sv
rtl/rx_byte_if.sv
rtl/utmi_rx_capture.sv
rtl/crc16_usb.sv
rtl/payload_crc_strip.sv
rtl/rx_sequencer.sv
rtl/usb_rx_decode.sv
verif/usb_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the usb_rx_decode testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module usb_rx_tb \
  -f usb_rx_decode.f -o usb_rx_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/usb_rx_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

/* verif/usb_rx_tb_tasks.svh */
// reference crc16, reflected polynomial, one byte lsb first
function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic [7:0] b);
  logic [15:0] c;
  c = crc;
  for (int k = 0; k < 8; k++)
  begin
    if (c[0] ^ b[k])
    begin
      c = {1'b0, c[15:1]} ^ CRC16_POLY_REV;
    end
    else
    begin
      c = {1'b0, c[15:1]};
    end
  end
  return c;
endfunction

// turns one table row into a cycle by cycle UTMI sequence
task automatic build_steps(input row_t r);
  logic [7:0]  pkt[$];
  logic [7:0]  b;
  logic [15:0] crc;
  step_t       st;
  int          mid;
  steps.delete();
  payload_q.delete();
  st = '0;
  st.start_in = ~r.hs;
  st.start_hs = r.hs;
  steps.push_back(st);
  if (!r.no_pkt)
  begin
    pkt.push_back(r.pid);
    if (!r.hs)
    begin
      crc = CRC16_INIT;
      for (int i = 0; i < int'(r.len); i++)
      begin
        b = 8'($urandom);
        payload_q.push_back(b);
        pkt.push_back(b);
        crc = crc16_step(crc, b);
      end
      crc = ~crc;
      if (r.bad_crc)
      begin
        crc = crc ^ 16'h8001;
      end
      // low byte first on the wire
      pkt.push_back(crc[7:0]);
      pkt.push_back(crc[15:8]);
    end
    // rx_active leads the first byte by one cycle
    st = '0;
    st.active = 1'b1;
    steps.push_back(st);
    mid = pkt.size() / 2;
    foreach (pkt[i])
    begin
      st = '0;
      st.active = 1'b1;
      st.valid = 1'b1;
      st.data = pkt[i];
      st.err = r.rx_err && (i == mid);
      steps.push_back(st);
    end
    st = '0;
    steps.push_back(st);
  end
endtask

task automatic drive_step(input step_t st);
  in_transfer_i <= st.start_in;
  hs_transfer_i <= st.start_hs;
  rx_active_i   <= st.active;
  rx_valid_i    <= st.valid;
  rx_error_i    <= st.err;
  rx_data_i     <= st.data;
endtask

// plays the steps, collects payload strobes and the report cycle
task automatic run_packet(input logic toggle);
  int    idx;
  logic  seen;
  step_t st;
  idx = 0;
  seen = 1'b0;
  got_q.delete();
  while (idx < steps.size() || !seen)
  begin
    @(posedge CLK);
    if (idx == 0)
    begin
      data_toggle_i <= toggle;
    end
    if (idx < steps.size())
    begin
      st = steps[idx];
      idx++;
    end
    else
    begin
      st = '0;
    end
    drive_step(st);
    @(negedge CLK);
    if (rx_data_valid_o)
    begin
      got_q.push_back(rx_data_o);
    end
    if (!seen && (hs_ready_o || data_ready_o))
    begin
      seen = 1'b1;
      got_hs = hs_ready_o;
      got_data = data_ready_o;
      got_count = data_count_o;
      got_flags = {ack_o, nak_o, stall_o, data_ok_o, crc_error_o, timeout_o,
                   toggle_error_o, pid_error_o, rx_error_o};
    end
  end
endtask

/* verif/usb_rx_tb.sv */
module usb_rx_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import usb_rx_pkg::*;

  // result bits in DUT output order, ack_o on top
  localparam logic [8:0] F_ACK   = 9'h100;
  localparam logic [8:0] F_NAK   = 9'h080;
  localparam logic [8:0] F_STALL = 9'h040;
  localparam logic [8:0] F_OK    = 9'h020;
  localparam logic [8:0] F_CRC   = 9'h010;
  localparam logic [8:0] F_TMO   = 9'h008;
  localparam logic [8:0] F_TOG   = 9'h004;
  localparam logic [8:0] F_PID   = 9'h002;
  localparam logic [8:0] F_RX    = 9'h001;
  localparam int NUM_CASES = 15;

  typedef struct packed {
    logic       hs;
    logic       no_pkt;
    logic [7:0] pid;
    logic [7:0] len;
    logic       tog;
    logic       bad_crc;
    logic       rx_err;
    logic [8:0] exp;
  } row_t;

  typedef struct packed {
    logic       start_in;
    logic       start_hs;
    logic       active;
    logic       valid;
    logic       err;
    logic [7:0] data;
  } step_t;

  // hs, no packet, pid, payload length, toggle, bad crc, rx error, expected flags
  localparam row_t CASES [NUM_CASES] = '{
    '{1'b1, 1'b0, PID_ACK,   8'd0,                 1'b0, 1'b0, 1'b0, F_ACK},
    '{1'b1, 1'b0, PID_NAK,   8'd0,                 1'b0, 1'b0, 1'b0, F_NAK},
    '{1'b1, 1'b0, PID_STALL, 8'd0,                 1'b0, 1'b0, 1'b0, F_STALL},
    '{1'b0, 1'b0, PID_DATA0, 8'd0,                 1'b0, 1'b0, 1'b0, F_OK},
    '{1'b0, 1'b0, PID_DATA1, 8'd5,                 1'b1, 1'b0, 1'b0, F_OK},
    '{1'b0, 1'b0, PID_DATA0, 8'(MAX_PAYLOAD),      1'b0, 1'b0, 1'b0, F_OK},
    '{1'b0, 1'b0, PID_DATA1, 8'(MAX_PAYLOAD),      1'b1, 1'b0, 1'b0, F_OK},
    '{1'b0, 1'b0, PID_DATA0, 8'd5,                 1'b0, 1'b1, 1'b0, F_CRC},
    '{1'b0, 1'b0, PID_DATA1, 8'(MAX_PAYLOAD + 4),  1'b1, 1'b0, 1'b0, F_CRC},
    '{1'b0, 1'b0, PID_DATA1, 8'd5,                 1'b0, 1'b0, 1'b0, F_TOG},
    '{1'b0, 1'b0, 8'hC2,     8'd4,                 1'b0, 1'b0, 1'b0, F_PID},
    '{1'b0, 1'b0, PID_ACK,   8'd0,                 1'b0, 1'b0, 1'b0, F_PID},
    '{1'b0, 1'b0, PID_DATA0, 8'd8,                 1'b0, 1'b0, 1'b1, F_RX},
    '{1'b1, 1'b1, 8'h00,     8'd0,                 1'b0, 1'b0, 1'b0, F_TMO},
    '{1'b0, 1'b1, 8'h00,     8'd0,                 1'b0, 1'b0, 1'b0, F_TMO}
  };

  logic                CLK;
  logic                RST;
  logic                in_transfer_i;
  logic                hs_transfer_i;
  logic                data_toggle_i;
  logic                info_ready_i;
  logic                rx_valid_i;
  logic                rx_active_i;
  logic                rx_error_i;
  logic [BYTE_W-1:0]   rx_data_i;
  logic [BYTE_W-1:0]   rx_data_o;
  logic                rx_data_valid_o;
  logic [COUNT_W-1:0]  data_count_o;
  logic                hs_ready_o;
  logic                data_ready_o;
  logic                ack_o;
  logic                nak_o;
  logic                stall_o;
  logic                data_ok_o;
  logic                crc_error_o;
  logic                timeout_o;
  logic                toggle_error_o;
  logic                pid_error_o;
  logic                rx_error_o;

  step_t              steps[$];
  logic [7:0]         payload_q[$];
  logic [7:0]         got_q[$];
  logic [8:0]         got_flags;
  logic               got_hs;
  logic               got_data;
  logic [COUNT_W-1:0] got_count;
  row_t               row;
  int                 case_errors = 0;
  int                 total_errors = 0;
  int                 failed_cases = 0;
  int                 cycles = 0;
  int                 cycle_limit;
  string              flag_names [9] = '{"ack_o", "nak_o", "stall_o", "data_ok_o",
                                         "crc_error_o", "timeout_o", "toggle_error_o",
                                         "pid_error_o", "rx_error_o"};

  `include "usb_rx_tb_tasks.svh"

  usb_rx_decode u_dut (.*);

  initial
  begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // packet bytes plus per case overhead, timeouts add the full wait
  function automatic int run_limit();
    int total;
    total = 500;
    for (int i = 0; i < NUM_CASES; i++)
    begin
      total += 12 + (CASES[i].hs ? 1 : int'(CASES[i].len) + 3);
      if (CASES[i].no_pkt)
      begin
        total += RX_TIMEOUT_CYCLES;
      end
    end
    return total;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp)
    else
    begin
      $display("[FAIL] %0t ns %s = %0h, expected %0h", $time, name, got, exp);
      case_errors++;
      total_errors++;
    end
  endtask

  task automatic check_case(input row_t r);
    int exp_count;
    check_value("hs_ready_o", 32'(got_hs), 32'(r.hs));
    check_value("data_ready_o", 32'(got_data), 32'(!r.hs));
    for (int f = 0; f < 9; f++)
    begin
      check_value(flag_names[f], 32'(got_flags[8-f]), 32'(r.exp[8-f]));
    end
    if ((r.exp & F_OK) != '0)
    begin
      check_value("rx_data_valid_o count", got_q.size(), int'(r.len));
      for (int i = 0; i < got_q.size() && i < payload_q.size(); i++)
      begin
        check_value("rx_data_o", 32'(got_q[i]), 32'(payload_q[i]));
      end
      exp_count = int'(r.len);
    end
    else
    begin
      exp_count = got_q.size();
    end
    check_value("data_count_o", 32'(got_count), exp_count);
  endtask

  always @(posedge CLK)
  begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("run stopped at cycle %0d, a case never reported a result", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  initial
  begin
    RST           <= 1'b0;
    in_transfer_i <= 1'b0;
    hs_transfer_i <= 1'b0;
    data_toggle_i <= 1'b0;
    info_ready_i  <= 1'b0;
    rx_valid_i    <= 1'b0;
    rx_active_i   <= 1'b0;
    rx_error_i    <= 1'b0;
    rx_data_i     <= '0;
    void'($urandom(32'hdddd));
    cycle_limit = run_limit();
    repeat (3) @(posedge CLK);
    RST <= 1'b1;
    repeat (2) @(posedge CLK);
    for (int i = 0; i < NUM_CASES; i++)
    begin
      row = CASES[i];
      case_errors = 0;
      build_steps(row);
      run_packet(row.tog);
      check_case(row);
      if (case_errors != 0)
      begin
        failed_cases++;
      end
      $display("case %0d: pid %02h, %0d payload bytes, %0d errors",
               i, row.pid, row.len, case_errors);
      // let a trailing packet end pass before the next start
      repeat (4) @(posedge CLK);
    end
    $display("%0d cases run, %0d failed, %0d check errors",
             NUM_CASES, failed_cases, total_errors);
    if (failed_cases == 0)
    begin
      $display("Finished with no errors");
    end
    else
    begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* rtl/usb_rx_decode.sv */
module usb_rx_decode (
  input  logic                           CLK,
  input  logic                           RST,
  input  logic                           in_transfer_i,
  input  logic                           hs_transfer_i,
  input  logic                           data_toggle_i,
  input  logic                           info_ready_i,
  input  logic                           rx_valid_i,
  input  logic                           rx_active_i,
  input  logic                           rx_error_i,
  input  logic [usb_rx_pkg::BYTE_W-1:0]  rx_data_i,
  output logic [usb_rx_pkg::BYTE_W-1:0]  rx_data_o,
  output logic                           rx_data_valid_o,
  output logic [usb_rx_pkg::COUNT_W-1:0] data_count_o,
  output logic                           hs_ready_o,
  output logic                           data_ready_o,
  output logic                           ack_o,
  output logic                           nak_o,
  output logic                           stall_o,
  output logic                           data_ok_o,
  output logic                           crc_error_o,
  output logic                           timeout_o,
  output logic                           toggle_error_o,
  output logic                           pid_error_o,
  output logic                           rx_error_o
);
  import usb_rx_pkg::*;

  logic               strip_clear;
  logic               strip_enable;
  logic [COUNT_W-1:0] payload_count;
  logic               crc_ok;

  rx_byte_if u_byte_if ();

  utmi_rx_capture u_capture (
    .CLK         (CLK),
    .RST         (RST),
    .rx_valid_i  (rx_valid_i),
    .rx_active_i (rx_active_i),
    .rx_error_i  (rx_error_i),
    .rx_data_i   (rx_data_i),
    .byte_o      (u_byte_if.source)
  );

  payload_crc_strip u_strip (
    .CLK             (CLK),
    .RST             (RST),
    .byte_i          (u_byte_if.sink),
    .clear_i         (strip_clear),
    .enable_i        (strip_enable),
    .payload_o       (rx_data_o),
    .payload_valid_o (rx_data_valid_o),
    .payload_count_o (payload_count),
    .crc_ok_o        (crc_ok)
  );

  rx_sequencer u_seq (
    .CLK             (CLK),
    .RST             (RST),
    .byte_i          (u_byte_if.sink),
    .in_transfer_i   (in_transfer_i),
    .hs_transfer_i   (hs_transfer_i),
    .data_toggle_i   (data_toggle_i),
    .info_ready_i    (info_ready_i),
    .payload_count_i (payload_count),
    .crc_ok_i        (crc_ok),
    .strip_clear_o   (strip_clear),
    .strip_enable_o  (strip_enable),
    .data_count_o    (data_count_o),
    .hs_ready_o      (hs_ready_o),
    .data_ready_o    (data_ready_o),
    .ack_o           (ack_o),
    .nak_o           (nak_o),
    .stall_o         (stall_o),
    .data_ok_o       (data_ok_o),
    .crc_error_o     (crc_error_o),
    .timeout_o       (timeout_o),
    .toggle_error_o  (toggle_error_o),
    .pid_error_o     (pid_error_o),
    .rx_error_o      (rx_error_o)
  );

endmodule

/* rtl/rx_sequencer.sv */
module rx_sequencer (
  input  logic                           CLK,
  input  logic                           RST,
  rx_byte_if.sink                        byte_i,
  input  logic                           in_transfer_i,
  input  logic                           hs_transfer_i,
  input  logic                           data_toggle_i,
  input  logic                           info_ready_i,
  input  logic [usb_rx_pkg::COUNT_W-1:0] payload_count_i,
  input  logic                           crc_ok_i,
  output logic                           strip_clear_o,
  output logic                           strip_enable_o,
  output logic [usb_rx_pkg::COUNT_W-1:0] data_count_o,
  output logic                           hs_ready_o,
  output logic                           data_ready_o,
  output logic                           ack_o,
  output logic                           nak_o,
  output logic                           stall_o,
  output logic                           data_ok_o,
  output logic                           crc_error_o,
  output logic                           timeout_o,
  output logic                           toggle_error_o,
  output logic                           pid_error_o,
  output logic                           rx_error_o
);
  import usb_rx_pkg::*;

  typedef struct packed {
    logic ack;
    logic nak;
    logic stall;
    logic ok;
    logic crc;
    logic timeout;
    logic toggle;
    logic pid;
    logic rx;
  } result_t;

  rx_state_t          state;
  result_t            res_q;
  logic               is_hs;
  logic [TIMEOUT_W-1:0] timer;
  logic [COUNT_W-1:0] byte_cnt;
  logic               start;
  logic               report;
  logic [BYTE_W-1:0]  pid;
  logic               pid_bad;
  logic               pid_data;
  logic               toggle_ok;

  assign start     = in_transfer_i | hs_transfer_i;
  assign pid       = byte_i.byte_data;
  // check nibble must be the complement of the type nibble
  assign pid_bad   = (pid[7:4] != ~pid[3:0]);
  assign pid_data  = (pid == PID_DATA0) | (pid == PID_DATA1);
  assign toggle_ok = data_toggle_i ? (pid == PID_DATA1) : (pid == PID_DATA0);

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      state    <= IDLE;
      res_q    <= '0;
      is_hs    <= 1'b0;
      timer    <= '0;
      byte_cnt <= '0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (start)
          begin
            state    <= WAIT_PID;
            is_hs    <= hs_transfer_i;
            res_q    <= '0;
            timer    <= '0;
            byte_cnt <= '0;
          end
        end
        WAIT_PID:
        begin
          timer <= timer + TIMEOUT_W'(1);
          if (byte_i.byte_valid)
          begin
            state <= DRAIN;
            if (pid_bad)
            begin
              res_q.pid <= 1'b1;
            end
            else if (is_hs && pid == PID_ACK)
            begin
              state     <= REPORT;
              res_q.ack <= 1'b1;
            end
            else if (is_hs && pid == PID_NAK)
            begin
              state     <= REPORT;
              res_q.nak <= 1'b1;
            end
            else if (is_hs && pid == PID_STALL)
            begin
              state       <= REPORT;
              res_q.stall <= 1'b1;
            end
            else if (!is_hs && pid_data && toggle_ok)
            begin
              state <= RX_DATA;
            end
            else if (!is_hs && pid_data)
            begin
              res_q.toggle <= 1'b1;
            end
            else
            begin
              res_q.pid <= 1'b1;
            end
          end
          else if (byte_i.pkt_end)
          begin
            // packet ended before any byte
            state    <= REPORT;
            res_q.rx <= 1'b1;
          end
          else if (timer == TIMEOUT_W'(RX_TIMEOUT_CYCLES - 1))
          begin
            state         <= REPORT;
            res_q.timeout <= 1'b1;
          end
        end
        RX_DATA:
        begin
          if (byte_i.pkt_end)
          begin
            state <= REPORT;
            if (byte_i.pkt_error)
            begin
              res_q.rx <= 1'b1;
            end
            else if (crc_ok_i)
            begin
              res_q.ok <= 1'b1;
            end
            else
            begin
              res_q.crc <= 1'b1;
            end
          end
          else if (byte_i.byte_valid)
          begin
            byte_cnt <= byte_cnt + COUNT_W'(1);
            // oversized packet
            if (byte_cnt == COUNT_W'(MAX_PAYLOAD + CRC_BYTES))
            begin
              state     <= DRAIN;
              res_q.crc <= 1'b1;
            end
          end
        end
        DRAIN:
        begin
          if (byte_i.pkt_end)
          begin
            state <= REPORT;
          end
        end
        REPORT:
        begin
          if (!info_ready_i)
          begin
            state <= IDLE;
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
    end
  end

  assign report         = (state == REPORT);
  assign strip_clear_o  = (state == IDLE) & start;
  assign strip_enable_o = (state == RX_DATA);

  assign hs_ready_o     = report & is_hs;
  assign data_ready_o   = report & ~is_hs;
  assign data_count_o   = data_ready_o ? payload_count_i : '0;
  assign ack_o          = report & res_q.ack;
  assign nak_o          = report & res_q.nak;
  assign stall_o        = report & res_q.stall;
  assign data_ok_o      = report & res_q.ok;
  assign crc_error_o    = report & res_q.crc;
  assign timeout_o      = report & res_q.timeout;
  assign toggle_error_o = report & res_q.toggle;
  assign pid_error_o    = report & res_q.pid;
  assign rx_error_o     = report & res_q.rx;

endmodule

/* rtl/payload_crc_strip.sv */
module payload_crc_strip (
  input  logic                           CLK,
  input  logic                           RST,
  rx_byte_if.sink                        byte_i,
  input  logic                           clear_i,
  input  logic                           enable_i,
  output logic [usb_rx_pkg::BYTE_W-1:0]  payload_o,
  output logic                           payload_valid_o,
  output logic [usb_rx_pkg::COUNT_W-1:0] payload_count_o,
  output logic                           crc_ok_o
);
  import usb_rx_pkg::*;

  logic [BYTE_W-1:0] hold_new;
  logic [BYTE_W-1:0] hold_old;
  logic [1:0]        fill;
  logic              line_full;
  logic              push;
  logic [15:0]       crc;

  assign line_full = (fill == 2'(CRC_BYTES));
  // oldest byte leaves the line only once two are held
  assign push      = enable_i & byte_i.byte_valid & line_full;

  always_ff @(posedge CLK)
  begin
    if (enable_i && byte_i.byte_valid)
    begin
      hold_old <= hold_new;
      hold_new <= byte_i.byte_data;
    end
  end

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      fill            <= '0;
      payload_o       <= '0;
      payload_valid_o <= 1'b0;
      payload_count_o <= '0;
    end
    else if (clear_i)
    begin
      fill            <= '0;
      payload_valid_o <= 1'b0;
      payload_count_o <= '0;
    end
    else
    begin
      payload_valid_o <= push;
      if (enable_i && byte_i.byte_valid && !line_full)
      begin
        fill <= fill + 2'd1;
      end
      if (push)
      begin
        payload_o       <= hold_old;
        payload_count_o <= payload_count_o + COUNT_W'(1);
      end
    end
  end

  crc16_usb u_crc (
    .CLK      (CLK),
    .RST      (RST),
    .clear_i  (clear_i),
    .enable_i (push),
    .data_i   (hold_old),
    .crc_o    (crc)
  );

  // low byte arrives first
  assign crc_ok_o = line_full & ({hold_new, hold_old} == ~crc);

endmodule

/* rtl/crc16_usb.sv */
module crc16_usb (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          clear_i,
  input  logic                          enable_i,
  input  logic [usb_rx_pkg::BYTE_W-1:0] data_i,
  output logic [15:0]                   crc_o
);
  import usb_rx_pkg::*;

  logic [15:0] crc_next;

  // eight serial steps unrolled, lsb first
  always_comb
  begin
    crc_next = crc_o;
    for (int i = 0; i < BYTE_W; i++)
    begin
      if (crc_next[0] ^ data_i[i])
      begin
        crc_next = (crc_next >> 1) ^ CRC16_POLY_REV;
      end
      else
      begin
        crc_next = crc_next >> 1;
      end
    end
  end

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      crc_o <= CRC16_INIT;
    end
    else if (clear_i)
    begin
      crc_o <= CRC16_INIT;
    end
    else if (enable_i)
    begin
      crc_o <= crc_next;
    end
  end

endmodule

/* rtl/utmi_rx_capture.sv */
module utmi_rx_capture (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          rx_valid_i,
  input  logic                          rx_active_i,
  input  logic                          rx_error_i,
  input  logic [usb_rx_pkg::BYTE_W-1:0] rx_data_i,
  rx_byte_if.source                     byte_o
);
  import usb_rx_pkg::*;

  logic active_q;

  // captured byte
  always_ff @(posedge CLK)
  begin
    if (rx_valid_i)
    begin
      byte_o.byte_data <= rx_data_i;
    end
  end

  always_ff @(posedge CLK or negedge RST)
  begin
    if (!RST)
    begin
      active_q          <= 1'b0;
      byte_o.byte_valid <= 1'b0;
      byte_o.pkt_end    <= 1'b0;
      byte_o.pkt_error  <= 1'b0;
    end
    else
    begin
      active_q          <= rx_active_i;
      byte_o.byte_valid <= rx_valid_i;
      // falling edge of rx_active
      byte_o.pkt_end    <= active_q & ~rx_active_i;
      // restart error tracking at each packet start
      if (rx_active_i && !active_q)
      begin
        byte_o.pkt_error <= rx_error_i;
      end
      else if (rx_error_i)
      begin
        byte_o.pkt_error <= 1'b1;
      end
    end
  end

endmodule

/* rtl/rx_byte_if.sv */
interface rx_byte_if;
  import usb_rx_pkg::*;

  logic              byte_valid;
  logic [BYTE_W-1:0] byte_data;
  logic              pkt_end;
  // sticky, valid together with pkt_end
  logic              pkt_error;

  modport source (
    output byte_valid, byte_data, pkt_end, pkt_error
  );

  modport sink (
    input byte_valid, byte_data, pkt_end, pkt_error
  );

endinterface

/* rtl/usb_rx_pkg.sv */
package usb_rx_pkg;

  // full PID bytes, check nibble in the upper half
  localparam logic [7:0] PID_DATA0 = 8'hC3;
  localparam logic [7:0] PID_DATA1 = 8'h4B;
  localparam logic [7:0] PID_ACK   = 8'hD2;
  localparam logic [7:0] PID_NAK   = 8'h5A;
  localparam logic [7:0] PID_STALL = 8'h1E;

  localparam int BYTE_W = 8;

  // packet limits
  localparam int MAX_PAYLOAD = 32;
  localparam int CRC_BYTES   = 2;
  localparam int COUNT_W     = 6;

  // wait for PID, roughly the bus turnaround budget
  localparam int RX_TIMEOUT_CYCLES = 24038;
  localparam int TIMEOUT_W         = 16;

  // reflected CRC16, LSB first
  localparam logic [15:0] CRC16_POLY_REV = 16'hA001;
  localparam logic [15:0] CRC16_INIT     = 16'hFFFF;

  typedef enum logic [3:0] {
    IDLE,
    WAIT_PID,
    RX_DATA,
    DRAIN,
    REPORT
  } rx_state_t;

endpackage
